// File: files.f
+incdir+verilog
verilog/smem_pkg.sv
verilog/smem_bank_if.sv
verilog/smem_req_dispatch.sv
verilog/smem_bank.sv
verilog/smem_rsp_merge.sv
verilog/shared_mem.sv
test/smem_checker.sv
test/smem_scoreboard.sv
test/tb_shared_mem.sv

// File: test/tb_shared_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "smem_macros.svh"

module tb_shared_mem import smem_pkg::*; ();

    localparam int MODE_FILL    = 0;
    localparam int MODE_READ    = 1;
    localparam int MODE_PARTIAL = 2;
    localparam int MODE_RANDOM  = 3;
    localparam int LANE_SPAN    = (1 << `SMEM_ADDR_WIDTH) / `SMEM_NUM_REQS;
    localparam int STALL_LIMIT  = 200;
    localparam int PHASE_LIMIT  = 20000;

    logic                         clk;
    logic                         reset;
    logic [`SMEM_NUM_REQS-1:0]    req_valid;
    logic [`SMEM_NUM_REQS-1:0]    req_rw;
    addr_t [`SMEM_NUM_REQS-1:0]   req_addr;
    byteen_t [`SMEM_NUM_REQS-1:0] req_byteen;
    word_t [`SMEM_NUM_REQS-1:0]   req_data;
    tag_t [`SMEM_NUM_REQS-1:0]    req_tag;
    logic [`SMEM_NUM_REQS-1:0]    req_ready;
    logic [`SMEM_NUM_REQS-1:0]    rsp_valid;
    word_t [`SMEM_NUM_REQS-1:0]   rsp_data;
    tag_t [`SMEM_NUM_REQS-1:0]    rsp_tag;
    logic [`SMEM_NUM_REQS-1:0]    rsp_ready;

    logic [31:0]                  lfsr;
    tag_t [`SMEM_NUM_REQS-1:0]    next_tag;
    bit                           ok;

    shared_mem UUT (.*);

    smem_scoreboard sb (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return {a, ~a, a ^ 8'h5a, a + 8'h33};
    endfunction

    task automatic issue_req(input int l, input int mode, input int idx);
        addr_t   a;
        logic    rw;
        byteen_t be;
        word_t   d;
        case (mode)
            MODE_FILL: begin
                a  = addr_t'(l * LANE_SPAN + idx);
                rw = 1'b1;
                be = '1;
                d  = fill_word(a);
            end
            MODE_READ: begin
                a  = addr_t'(l * LANE_SPAN + idx);
                rw = 1'b0;
                be = '0;
                d  = '0;
            end
            MODE_PARTIAL: begin
                a  = addr_t'(l * LANE_SPAN + idx * 4) + addr_t'(rand_bits(2));
                rw = 1'b1;
                be = byteen_t'(rand_bits(4));
                d  = rand_bits(32);
            end
            default: begin
                a = addr_t'(rand_bits(8));
                // Half the requests crowd into banks 0 and 1
                if (rand_bits(1) != 0) begin
                    a[1:0] = {1'b0, rand_bits(1) != 0};
                end
                rw = (rand_bits(1) != 0);
                be = byteen_t'(rand_bits(4));
                d  = rand_bits(32);
            end
        endcase
        req_valid[l]  <= 1'b1;
        req_rw[l]     <= rw;
        req_addr[l]   <= a;
        req_byteen[l] <= be;
        req_data[l]   <= d;
        req_tag[l]    <= next_tag[l];
        next_tag[l] = next_tag[l] + 1'b1;
    endtask

    // Sends per_lane requests on every lane, then waits until all reads are back
    task automatic run_phase(input int mode, input int per_lane, input bit use_bp);
        int                        sent [`SMEM_NUM_REQS];
        int                        stall [`SMEM_NUM_REQS];
        logic [`SMEM_NUM_REQS-1:0] live;
        int                        cycles;
        bit                        busy;
        live   = '0;
        cycles = 0;
        busy   = 1'b1;
        for (int l = 0; l < `SMEM_NUM_REQS; l++) begin
            sent[l]  = 0;
            stall[l] = 0;
        end
        while (ok && busy) begin
            @(posedge clk);
            cycles++;
            busy = (sb.pending_reads != 0);
            for (int l = 0; l < `SMEM_NUM_REQS; l++) begin
                if (live[l] && req_ready[l]) begin
                    live[l]  = 1'b0;
                    stall[l] = 0;
                end else if (live[l]) begin
                    stall[l]++;
                end
                if (!live[l] && sent[l] < per_lane
                        && (mode != MODE_RANDOM || rand_bits(2) != 0)) begin
                    issue_req(l, mode, sent[l]);
                    sent[l]++;
                    live[l] = 1'b1;
                end else if (!live[l]) begin
                    req_valid[l] <= 1'b0;
                end
                rsp_ready[l] <= !use_bp || (rand_bits(2) != 0);
                busy = busy || live[l] || (sent[l] < per_lane);
                if (stall[l] > STALL_LIMIT) begin
                    $display("Timeout: lane %0d request not accepted within %0d cycles",
                             l, STALL_LIMIT);
                    ok = 1'b0;
                end
            end
            if (ok && busy && cycles >= PHASE_LIMIT) begin
                $display("Timeout: phase not finished after %0d cycles, %0d reads outstanding",
                         cycles, sb.pending_reads);
                ok = 1'b0;
            end
        end
        rsp_ready <= '1;
    endtask

    initial begin
        reset      = 1'b1;
        req_valid  = '0;
        req_rw     = '0;
        req_addr   = '0;
        req_byteen = '0;
        req_data   = '0;
        req_tag    = '0;
        rsp_ready  = '1;
        next_tag   = '0;
        lfsr       = 32'h7f65;
        ok         = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        repeat (10) @(posedge clk);
        sb.report_test("no response after reset");

        run_phase(MODE_FILL, LANE_SPAN, 1'b0);
        run_phase(MODE_READ, LANE_SPAN, 1'b0);
        if (ok) sb.report_test("full word write and read");

        run_phase(MODE_PARTIAL, LANE_SPAN / 4, 1'b0);
        run_phase(MODE_READ, LANE_SPAN, 1'b0);
        if (ok) sb.report_test("byte enable writes");

        run_phase(MODE_RANDOM, 300, 1'b0);
        if (ok) sb.report_test("random traffic with bank conflicts");

        run_phase(MODE_RANDOM, 300, 1'b1);
        if (ok) sb.report_test("random traffic with back-pressure");

        if (!ok) begin
            sb.report_missing();
        end
        repeat (2) @(posedge clk);
        $display("Summary: %0d tests, %0d failed, %0d data errors, %0d assertion failures",
                 sb.tests_run, sb.tests_failed, sb.error_count, UUT.u_checker.failures);
        if (ok && sb.tests_failed == 0 && sb.error_count == 0
                && UUT.u_checker.failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/smem_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "smem_macros.svh"

module smem_scoreboard import smem_pkg::*; (
    input logic                         clk,
    input logic                         reset,
    input logic [`SMEM_NUM_REQS-1:0]    req_valid,
    input logic [`SMEM_NUM_REQS-1:0]    req_rw,
    input addr_t [`SMEM_NUM_REQS-1:0]   req_addr,
    input byteen_t [`SMEM_NUM_REQS-1:0] req_byteen,
    input word_t [`SMEM_NUM_REQS-1:0]   req_data,
    input tag_t [`SMEM_NUM_REQS-1:0]    req_tag,
    input logic [`SMEM_NUM_REQS-1:0]    req_ready,
    input logic [`SMEM_NUM_REQS-1:0]    rsp_valid,
    input word_t [`SMEM_NUM_REQS-1:0]   rsp_data,
    input tag_t [`SMEM_NUM_REQS-1:0]    rsp_tag,
    input logic [`SMEM_NUM_REQS-1:0]    rsp_ready
);

    localparam int NUM_TAGS = 1 << `SMEM_TAG_WIDTH;

    word_t model [1 << `SMEM_ADDR_WIDTH];
    bit    exp_valid [`SMEM_NUM_REQS][NUM_TAGS];
    word_t exp_data [`SMEM_NUM_REQS][NUM_TAGS];

    int pending_reads = 0;
    int error_count   = 0;
    int tests_run     = 0;
    int tests_failed  = 0;
    int errors_before = 0;

    // Inputs settle well before the falling edge, so these are the upcoming transfers
    always @(negedge clk) begin
        if (!reset) begin
            for (int l = 0; l < `SMEM_NUM_REQS; l++) begin
                if (rsp_valid[l] && rsp_ready[l]) begin
                    if (!exp_valid[l][rsp_tag[l]]) begin
                        $display("Lane %0d returned tag %0d with no read outstanding, at %0t",
                                 l, rsp_tag[l], $time);
                        error_count++;
                    end else begin
                        if (rsp_data[l] !== exp_data[l][rsp_tag[l]]) begin
                            $display("[FAIL] %0t lane %0d tag %0d read %h, expected %h", $time,
                                     l, rsp_tag[l], rsp_data[l], exp_data[l][rsp_tag[l]]);
                            error_count++;
                        end
                        exp_valid[l][rsp_tag[l]] = 1'b0;
                        pending_reads--;
                    end
                end
                if (req_valid[l] && req_ready[l]) begin
                    if (req_rw[l]) begin
                        for (int i = 0; i < `SMEM_WORD_SIZE; i++) begin
                            if (req_byteen[l][i]) begin
                                model[req_addr[l]][i*8 +: 8] = req_data[l][i*8 +: 8];
                            end
                        end
                    end else if (exp_valid[l][req_tag[l]]) begin
                        $display("Lane %0d reused tag %0d while its read was outstanding",
                                 l, req_tag[l]);
                        error_count++;
                    end else begin
                        exp_valid[l][req_tag[l]] = 1'b1;
                        exp_data[l][req_tag[l]]  = model[req_addr[l]];
                        pending_reads++;
                    end
                end
            end
        end
    end

    task automatic report_test(input string name);
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: %0d errors", tests_run, name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    task automatic report_missing();
        for (int l = 0; l < `SMEM_NUM_REQS; l++) begin
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (exp_valid[l][t]) begin
                    $display("Lane %0d tag %0d: read never returned", l, t);
                end
            end
        end
    endtask

endmodule

`default_nettype wire

// File: test/smem_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "smem_macros.svh"

module smem_checker import smem_pkg::*; (
    input logic                        clk,
    input logic                        reset,
    input logic [`SMEM_NUM_REQS-1:0]   req_valid,
    input logic [`SMEM_NUM_REQS-1:0]   req_ready,
    input logic [`SMEM_NUM_REQS-1:0]   rsp_valid,
    input word_t [`SMEM_NUM_REQS-1:0]  rsp_data,
    input tag_t [`SMEM_NUM_REQS-1:0]   rsp_tag,
    input logic [`SMEM_NUM_REQS-1:0]   rsp_ready
);

    int failures = 0;

    a_quiet_after_reset: assert property (@(posedge clk) reset |=> rsp_valid == '0)
        else begin
            failures++;
            $error("rsp_valid high in the cycle after reset");
        end

    // Ready only toward a lane that asks
    a_ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
        (req_ready & ~req_valid) == '0)
        else begin
            failures++;
            $error("req_ready high for a lane without req_valid");
        end

    for (genvar l = 0; l < `SMEM_NUM_REQS; l++) begin : g_lane
        a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
            rsp_valid[l] && !rsp_ready[l] |=>
                rsp_valid[l] && $stable(rsp_data[l]) && $stable(rsp_tag[l]))
            else begin
                failures++;
                $error("lane %0d response changed while stalled", l);
            end
    end

endmodule

bind shared_mem smem_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .rsp_tag   (rsp_tag),
    .rsp_ready (rsp_ready)
);

`default_nettype wire

// File: verilog/shared_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "smem_macros.svh"

module shared_mem import smem_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,

    // Lane requests
    input  logic [`SMEM_NUM_REQS-1:0]     req_valid,
    input  logic [`SMEM_NUM_REQS-1:0]     req_rw,
    input  addr_t [`SMEM_NUM_REQS-1:0]    req_addr,
    input  byteen_t [`SMEM_NUM_REQS-1:0]  req_byteen,
    input  word_t [`SMEM_NUM_REQS-1:0]    req_data,
    input  tag_t [`SMEM_NUM_REQS-1:0]     req_tag,
    output logic [`SMEM_NUM_REQS-1:0]     req_ready,

    // Lane read responses
    output logic [`SMEM_NUM_REQS-1:0]     rsp_valid,
    output word_t [`SMEM_NUM_REQS-1:0]    rsp_data,
    output tag_t [`SMEM_NUM_REQS-1:0]     rsp_tag,
    input  logic [`SMEM_NUM_REQS-1:0]     rsp_ready
);

    smem_bank_if bank_if [`SMEM_NUM_BANKS] ();

    smem_req_dispatch u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_rw     (req_rw),
        .req_addr   (req_addr),
        .req_byteen (req_byteen),
        .req_data   (req_data),
        .req_tag    (req_tag),
        .req_ready  (req_ready),
        .bank       (bank_if)
    );

    for (genvar b = 0; b < `SMEM_NUM_BANKS; b++) begin : g_bank
        smem_bank u_bank (
            .clk   (clk),
            .reset (reset),
            .port  (bank_if[b])
        );
    end

    smem_rsp_merge u_merge (
        .clk       (clk),
        .reset     (reset),
        .bank      (bank_if),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_tag   (rsp_tag),
        .rsp_ready (rsp_ready)
    );

endmodule

`default_nettype wire

// File: verilog/smem_rsp_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "smem_macros.svh"

module smem_rsp_merge import smem_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    smem_bank_if.merge                   bank [`SMEM_NUM_BANKS],
    output logic [`SMEM_NUM_REQS-1:0]    rsp_valid,
    output word_t [`SMEM_NUM_REQS-1:0]   rsp_data,
    output tag_t [`SMEM_NUM_REQS-1:0]    rsp_tag,
    input  logic [`SMEM_NUM_REQS-1:0]    rsp_ready
);

    localparam int BANK_SEL_BITS = $clog2(`SMEM_NUM_BANKS);

    logic [`SMEM_NUM_BANKS-1:0]                     bk_valid;
    word_t [`SMEM_NUM_BANKS-1:0]                    bk_data;
    tag_t [`SMEM_NUM_BANKS-1:0]                     bk_tag;
    lane_idx_t [`SMEM_NUM_BANKS-1:0]                bk_idx;
    logic [`SMEM_NUM_BANKS-1:0]                     bk_ready;

    logic [`SMEM_NUM_REQS-1:0]                      lane_any;
    logic [`SMEM_NUM_REQS-1:0][BANK_SEL_BITS-1:0]   lane_sel;
    logic [`SMEM_NUM_REQS-1:0]                      out_free;

    for (genvar b = 0; b < `SMEM_NUM_BANKS; b++) begin : g_bank
        assign bk_valid[b]       = bank[b].rsp_valid;
        assign bk_data[b]        = bank[b].rsp_data;
        assign bk_tag[b]         = bank[b].rsp_tag;
        assign bk_idx[b]         = bank[b].rsp_idx;
        assign bank[b].rsp_ready = bk_ready[b];
    end

    assign out_free = ~rsp_valid | rsp_ready;

    // Lowest bank wins for each lane
    always_comb begin
        lane_any = '0;
        lane_sel = '0;
        bk_ready = '0;
        for (int l = 0; l < `SMEM_NUM_REQS; l++) begin
            for (int b = `SMEM_NUM_BANKS - 1; b >= 0; b--) begin
                if (bk_valid[b] && (bk_idx[b] == lane_idx_t'(l))) begin
                    lane_any[l] = 1'b1;
                    lane_sel[l] = BANK_SEL_BITS'(b);
                end
            end
            if (lane_any[l] && out_free[l]) begin
                bk_ready[lane_sel[l]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= '0;
        end else begin
            for (int l = 0; l < `SMEM_NUM_REQS; l++) begin
                if (out_free[l]) begin
                    rsp_valid[l] <= lane_any[l];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `SMEM_NUM_REQS; l++) begin
            if (lane_any[l] && out_free[l]) begin
                rsp_data[l] <= bk_data[lane_sel[l]];
                rsp_tag[l]  <= bk_tag[lane_sel[l]];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/smem_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "smem_macros.svh"

module smem_bank import smem_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    smem_bank_if.bank port
);

    localparam int NUM_WORDS = 1 << `SMEM_BANK_ADDR_WIDTH;

    word_t mem [0:NUM_WORDS-1];

    // Request register
    logic       rq_valid;
    logic       rq_rw;
    bank_addr_t rq_addr;
    byteen_t    rq_byteen;
    word_t      rq_data;
    tag_t       rq_tag;
    lane_idx_t  rq_idx;

    // Read response register
    logic       rs_valid;
    word_t      rs_data;
    tag_t       rs_tag;
    lane_idx_t  rs_idx;

    logic req_fire;
    logic rs_free;
    logic rd_fire;
    logic rq_drain;

    assign rs_free  = !rs_valid || port.rsp_ready;
    assign rd_fire  = rq_valid && !rq_rw && rs_free;
    // Writes always leave, reads only if the response slot opens
    assign rq_drain = rq_valid && (rq_rw || rs_free);

    assign port.req_ready = !rq_valid || rq_drain;
    assign req_fire       = port.req_valid && port.req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rq_valid <= 1'b0;
            rs_valid <= 1'b0;
        end else begin
            if (req_fire) begin
                rq_valid <= 1'b1;
            end else if (rq_drain) begin
                rq_valid <= 1'b0;
            end
            if (rd_fire) begin
                rs_valid <= 1'b1;
            end else if (port.rsp_ready) begin
                rs_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rq_rw     <= port.req_rw;
            rq_addr   <= port.req_addr;
            rq_byteen <= port.req_byteen;
            rq_data   <= port.req_data;
            rq_tag    <= port.req_tag;
            rq_idx    <= port.req_idx;
        end
        if (rd_fire) begin
            rs_tag <= rq_tag;
            rs_idx <= rq_idx;
        end
    end

    // Single-port RAM with byte-masked write and registered read
    always_ff @(posedge clk) begin
        if (rq_valid && rq_rw) begin
            for (int i = 0; i < `SMEM_WORD_SIZE; i++) begin
                if (rq_byteen[i]) begin
                    mem[rq_addr][i*8 +: 8] <= rq_data[i*8 +: 8];
                end
            end
        end
        if (rd_fire) begin
            rs_data <= mem[rq_addr];
        end
    end

    assign port.rsp_valid = rs_valid;
    assign port.rsp_data  = rs_data;
    assign port.rsp_tag   = rs_tag;
    assign port.rsp_idx   = rs_idx;

endmodule

`default_nettype wire

// File: verilog/smem_req_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "smem_macros.svh"

module smem_req_dispatch import smem_pkg::*; (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [`SMEM_NUM_REQS-1:0]               req_valid,
    input  logic [`SMEM_NUM_REQS-1:0]               req_rw,
    input  addr_t [`SMEM_NUM_REQS-1:0]              req_addr,
    input  byteen_t [`SMEM_NUM_REQS-1:0]            req_byteen,
    input  word_t [`SMEM_NUM_REQS-1:0]              req_data,
    input  tag_t [`SMEM_NUM_REQS-1:0]               req_tag,
    output logic [`SMEM_NUM_REQS-1:0]               req_ready,
    smem_bank_if.dispatch                           bank [`SMEM_NUM_BANKS]
);

    localparam int BANK_SEL_BITS = $clog2(`SMEM_NUM_BANKS);

    logic [`SMEM_NUM_BANKS-1:0][`SMEM_NUM_REQS-1:0] lane_hit;
    logic [`SMEM_NUM_BANKS-1:0][`SMEM_NUM_REQS-1:0] lane_take;
    lane_idx_t [`SMEM_NUM_BANKS-1:0]                rr_ptr;
    lane_idx_t [`SMEM_NUM_BANKS-1:0]                winner;
    logic [`SMEM_NUM_BANKS-1:0]                     bank_fire;

    // First requesting lane at or after the pointer
    function automatic lane_idx_t rr_pick(input logic [`SMEM_NUM_REQS-1:0] hits,
                                          input lane_idx_t ptr);
        lane_idx_t cand;
        lane_idx_t pick;
        pick = ptr;
        for (int k = `SMEM_NUM_REQS - 1; k >= 0; k--) begin
            cand = ptr + lane_idx_t'(k);
            if (hits[cand]) begin
                pick = cand;
            end
        end
        return pick;
    endfunction

    for (genvar b = 0; b < `SMEM_NUM_BANKS; b++) begin : g_bank
        for (genvar l = 0; l < `SMEM_NUM_REQS; l++) begin : g_lane
            assign lane_hit[b][l] = req_valid[l]
                && (req_addr[l][BANK_SEL_BITS-1:0] == BANK_SEL_BITS'(b));
            assign lane_take[b][l] = bank_fire[b] && (winner[b] == lane_idx_t'(l));
        end

        assign winner[b] = rr_pick(lane_hit[b], rr_ptr[b]);

        assign bank[b].req_valid  = |lane_hit[b];
        assign bank[b].req_rw     = req_rw[winner[b]];
        assign bank[b].req_addr   = req_addr[winner[b]][`SMEM_ADDR_WIDTH-1:BANK_SEL_BITS];
        assign bank[b].req_byteen = req_byteen[winner[b]];
        assign bank[b].req_data   = req_data[winner[b]];
        assign bank[b].req_tag    = req_tag[winner[b]];
        assign bank[b].req_idx    = winner[b];

        assign bank_fire[b] = (|lane_hit[b]) && bank[b].req_ready;

        // Pointer moves past the winner only when it transfers
        always_ff @(posedge clk) begin
            if (reset) begin
                rr_ptr[b] <= '0;
            end else if (bank_fire[b]) begin
                rr_ptr[b] <= winner[b] + lane_idx_t'(1);
            end
        end
    end

    // A lane targets a single bank, so OR over banks
    always_comb begin
        req_ready = '0;
        for (int b = 0; b < `SMEM_NUM_BANKS; b++) begin
            req_ready = req_ready | lane_take[b];
        end
    end

endmodule

`default_nettype wire

// File: verilog/smem_bank_if.sv
`timescale 1ns/1ps
`default_nettype none

interface smem_bank_if import smem_pkg::*; ();

    // Request toward the bank
    logic       req_valid;
    logic       req_rw;
    bank_addr_t req_addr;
    byteen_t    req_byteen;
    word_t      req_data;
    tag_t       req_tag;
    lane_idx_t  req_idx;
    logic       req_ready;

    // Read response back to the merge
    logic       rsp_valid;
    word_t      rsp_data;
    tag_t       rsp_tag;
    lane_idx_t  rsp_idx;
    logic       rsp_ready;

    modport dispatch (
        output req_valid, req_rw, req_addr, req_byteen, req_data, req_tag, req_idx,
        input  req_ready
    );

    modport bank (
        input  req_valid, req_rw, req_addr, req_byteen, req_data, req_tag, req_idx,
        output req_ready,
        output rsp_valid, rsp_data, rsp_tag, rsp_idx,
        input  rsp_ready
    );

    modport merge (
        input  rsp_valid, rsp_data, rsp_tag, rsp_idx,
        output rsp_ready
    );

endinterface

`default_nettype wire

// File: verilog/smem_pkg.sv
`default_nettype none

`include "smem_macros.svh"

package smem_pkg;

    typedef logic [`SMEM_WORD_WIDTH-1:0] word_t;

    typedef logic [`SMEM_WORD_SIZE-1:0] byteen_t;

    // Full word address as seen by a lane
    typedef logic [`SMEM_ADDR_WIDTH-1:0] addr_t;

    // Word index inside one bank
    typedef logic [`SMEM_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    typedef logic [`SMEM_TAG_WIDTH-1:0] tag_t;

    // Requesting lane number
    typedef logic [$clog2(`SMEM_NUM_REQS)-1:0] lane_idx_t;

endpackage

`default_nettype wire

// File: verilog/smem_macros.svh
`ifndef SMEM_MACROS_SVH
`define SMEM_MACROS_SVH

// Lanes and banks
`define SMEM_NUM_REQS 4
`define SMEM_NUM_BANKS 4

// Word size in bytes and in bits
`define SMEM_WORD_SIZE 4
`define SMEM_WORD_WIDTH 32

// 64 words per bank
`define SMEM_BANK_ADDR_WIDTH 6

// Word address with the bank in its low bits
`define SMEM_ADDR_WIDTH 8

`define SMEM_TAG_WIDTH 8

`endif
